/* dv/fpm_checker.sv */
// port-level assertions for fpm_top, sampled on the rising edge; needs assertions enabled
`timescale 1ns/1ps
`default_nettype none

module fpm_checker (
  input logic              clk,
  input logic              rst_n,
  input fpm_pkg::fp_word_t fp_z,
  input logic              ovrf,
  input logic              udrf
);
  import fpm_pkg::*;

  a_reset_clears: assert property (@(posedge clk) !rst_n |=> fp_z == '0 && !ovrf && !udrf)
    else $error("outputs not cleared during reset");

  // result of the cleared input register is due one cycle after release
  a_release_next: assert property (@(posedge clk) $rose(rst_n) |=> !ovrf && !udrf)
    else $error("flag high one cycle after reset release");

  a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(ovrf && udrf))
    else $error("ovrf and udrf both high");

  a_ovrf_is_inf: assert property (@(posedge clk) disable iff (!rst_n)
    ovrf |-> fp_z[FRC_W +: EXP_W] == '1 && fp_z[FRC_W-1:0] == '0)
    else $error("ovrf without an infinity result");

  a_udrf_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
    udrf |-> fp_z[EXP_W+FRC_W-1:0] == '0)
    else $error("udrf without a zero result");

endmodule

bind fpm_top fpm_checker checker_i (
  .clk   (clk),
  .rst_n (rst_n),
  .fp_z  (fp_z),
  .ovrf  (ovrf),
  .udrf  (udrf)
);

`default_nettype wire

/* dv/fpm_golden.hex */
// columns: rounding mode, operand x, operand y, expected fp_z, expected ovrf, expected udrf
// modes 0 rne 1 rtz 2 rdn 3 rup 4 rmm; the single word ffffffff ends the list
0 3fc00000 40000000 40400000 0 0
1 3fc00000 40000000 40400000 0 0
2 3fc00000 40000000 40400000 0 0
3 3fc00000 40000000 40400000 0 0
4 3fc00000 40000000 40400000 0 0
2 c0400000 3e800000 bf400000 0 0
0 3f800001 3fc00000 3fc00002 0 0
1 3f800001 3fc00000 3fc00001 0 0
2 bf800001 3fc00000 bfc00002 0 0
0 3f800003 3fc00000 3fc00004 0 0
4 3f800003 3fc00000 3fc00005 0 0
3 3f800001 3f800001 3f800003 0 0
2 bf800001 3f800001 bf800003 0 0
3 3fffffff 3fffffff 407fffff 0 0
0 3ffffffe 3f800001 40000000 0 0
1 3ffffffe 3f800001 3fffffff 0 0
0 71800000 71800000 7f800000 1 0
1 f1800000 71800000 ff800000 1 0
0 7f000000 40000000 7f800000 1 0
0 0d800000 0d800000 00000000 0 1
0 20000000 20000000 00800000 0 0
0 9f800000 20000000 80000000 0 1
0 7f800000 40000000 7f800000 1 0
0 00000000 40400000 00000000 0 1
0 00000001 40000000 00000000 0 1
0 7fc00000 3f800000 7fc00000 0 0
0 7f800000 00000000 7fc00000 0 0
3 80000000 ff800000 7fc00000 0 0
ffffffff

/* dv/fpm_tb.sv */
// run from the project root; golden vectors come from dv/fpm_golden.hex and end with ffffffff
`timescale 1ns/1ps
`default_nettype none

module fpm_tb;
  import fpm_pkg::*;

  localparam int          MAX_VEC   = 64;
  localparam int          VEC_WORDS = 6;  // mode, x, y, z, ovrf, udrf
  localparam logic [31:0] END_MARK  = 32'hffff_ffff;

  logic     clk;
  logic     rst_n;
  rmode_t   r_mode;
  fp_word_t fp_x;
  fp_word_t fp_y;
  fp_word_t fp_z;
  logic     ovrf;
  logic     udrf;

  logic [31:0] golden [MAX_VEC*VEC_WORDS];
  int          num_vec;
  int          cycles = 0;

  tb_clock clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  fpm_top fpm_top_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .r_mode (r_mode),
    .fp_x   (fp_x),
    .fp_y   (fp_y),
    .fp_z   (fp_z),
    .ovrf   (ovrf),
    .udrf   (udrf)
  );

  task automatic check(input string name, input string where, input logic [31:0] got,
                       input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch %s at %s: got %h expected %h", name, where, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  function automatic int count_vectors();
    for (int k = 0; k < MAX_VEC; k++) begin
      if (golden[k*VEC_WORDS] == END_MARK) return k;
    end
    return -1;
  endfunction

  task automatic drive_vector(input int k);
    r_mode = rmode_t'(golden[k*VEC_WORDS]);
    fp_x   = golden[k*VEC_WORDS+1];
    fp_y   = golden[k*VEC_WORDS+2];
  endtask

  task automatic check_vector(input int k);
    string where;
    where = $sformatf("vector %0d", k);
    check("fp_z", where, fp_z, golden[k*VEC_WORDS+3]);
    check("ovrf", where, {31'b0, ovrf}, golden[k*VEC_WORDS+4]);
    check("udrf", where, {31'b0, udrf}, golden[k*VEC_WORDS+5]);
  endtask

  task automatic check_cleared(input string where);
    check("fp_z", where, fp_z, 32'h0);
    check("ovrf", where, {31'b0, ovrf}, 32'h0);
    check("udrf", where, {31'b0, udrf}, 32'h0);
  endtask

  initial begin
    r_mode = RM_RNE;
    fp_x   = 32'h3f80_0000;  // idle on 1.0 x 1.0
    fp_y   = 32'h3f80_0000;
    $readmemh("dv/fpm_golden.hex", golden);
    num_vec = count_vectors();
    if (num_vec <= 0) begin
      $display("golden file is empty or lacks its end marker");
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
    wait (rst_n === 1'b1);
    check_cleared("reset release");
    // vector t goes in on this falling edge, vector t-2 is due now
    for (int t = 0; t < num_vec + 2; t++) begin
      @(negedge clk);
      if (t >= 2) begin
        check_vector(t - 2);
      end else if (t == 0) begin
        check_cleared("first cycle after reset");
      end
      if (t < num_vec) drive_vector(t);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > num_vec + 20) begin
      $display("timeout after %0d cycles, vectors did not finish", cycles);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
// free-running 10 ns clock; rst_n low for the first three rising edges, released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);  // release away from the sampling edge
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* filelist.f */
verilog/fpm_pkg.sv
verilog/fpm_operand_if.sv
verilog/fpm_unpack.sv
verilog/booth_recoder.sv
verilog/booth_selector.sv
verilog/pp_accumulate.sv
verilog/fpm_round_pack.sv
verilog/fpm_top.sv
dv/tb_clock.sv
dv/fpm_checker.sv
dv/fpm_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator; the exit status is the simulation's
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module fpm_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed"
  exit "$status"
fi

./obj_dir/Vfpm_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit "$status"
fi

exit 0

/* verilog/booth_recoder.sv */
// radix-8 recoding of an unsigned multiplier; mult3 holds 3*mult without its lsb
`timescale 1ns/1ps
`default_nettype none

module booth_recoder (
  fpm_operand_if.consumer              ops,
  output fpm_pkg::mant_t               mult,
  output logic [fpm_pkg::MANT_W:0]     mult3,
  output logic [3:0]                   digit_sel [fpm_pkg::PP_COUNT],
  output logic [fpm_pkg::PP_COUNT-1:0] digit_neg
);
  import fpm_pkg::*;

  logic [3*PP_COUNT:0] mr_ext;  // multiplier with a zero below bit 0 and zeros on top

  assign mult = ops.mant_y;

  // 3y >> 1 equals y + (y >> 1); the dropped lsb is y[0]
  assign mult3 = {1'b0, ops.mant_y} + {2'b00, ops.mant_y[MANT_W-1:1]};

  assign mr_ext = {{(3*PP_COUNT-MANT_W){1'b0}}, ops.mant_x, 1'b0};

  always_comb begin
    logic [3:0] win;
    logic [2:0] t;
    logic [2:0] mag;
    for (int i = 0; i < PP_COUNT; i++) begin
      win = mr_ext[3*i +: 4];
      t   = win[2:0] ^ {3{win[3]}};  // complement gives |digit| for negative windows
      mag = {1'b0, t[2], 1'b0} + {2'b00, t[1]} + {2'b00, t[0]};
      case (mag)
        3'd1:    digit_sel[i] = 4'b0001;
        3'd2:    digit_sel[i] = 4'b0010;
        3'd3:    digit_sel[i] = 4'b0100;
        3'd4:    digit_sel[i] = 4'b1000;
        default: digit_sel[i] = 4'b0000;
      endcase
      digit_neg[i] = win[3];
    end
  end

endmodule

`default_nettype wire

/* verilog/booth_selector.sv */
// one partial product; a negative digit yields the ones' complement, +1 is added downstream
`timescale 1ns/1ps
`default_nettype none

module booth_selector (
  input  fpm_pkg::mant_t           mult,
  input  logic [fpm_pkg::MANT_W:0] mult3,
  input  logic [3:0]               sel,    // one-hot x1, x2, x3, x4
  input  logic                     neg,
  output fpm_pkg::pp_t             pp
);
  import fpm_pkg::*;

  pp_t m1, m2, m3, m4;
  pp_t mag;

  assign m1 = {3'b000, mult};
  assign m2 = {2'b00, mult, 1'b0};
  assign m3 = {1'b0, mult3, mult[0]};  // lsb restored
  assign m4 = {1'b0, mult, 2'b00};

  assign mag = ({PP_W{sel[0]}} & m1) | ({PP_W{sel[1]}} & m2) |
               ({PP_W{sel[2]}} & m3) | ({PP_W{sel[3]}} & m4);

  assign pp = mag ^ {PP_W{neg}};

endmodule

`default_nettype wire

/* verilog/fpm_operand_if.sv */
// registered operands, split and classified; no handshake, values change every cycle
`timescale 1ns/1ps
`default_nettype none

interface fpm_operand_if;
  import fpm_pkg::*;

  logic   sign_z;   // xor of operand signs
  exp_t   exp_x;
  exp_t   exp_y;
  mant_t  mant_x;   // hidden bit always set
  mant_t  mant_y;
  rmode_t r_mode;
  logic   nan_in;   // nan operand or inf times zero
  logic   inf_in;
  logic   zer_in;

  modport producer (
    output sign_z, exp_x, exp_y, mant_x, mant_y, r_mode, nan_in, inf_in, zer_in
  );

  modport consumer (
    input sign_z, exp_x, exp_y, mant_x, mant_y, r_mode, nan_in, inf_in, zer_in
  );

endinterface

`default_nettype wire

/* verilog/fpm_pkg.sv */
// single precision only; subnormal operands are read as zero and results never go subnormal
`default_nettype none

package fpm_pkg;

  localparam int FRC_W    = 23;
  localparam int EXP_W    = 8;
  localparam int EXP_BIAS = 127;
  localparam int MANT_W   = FRC_W + 1;   // hidden bit included
  localparam int PP_COUNT = 9;           // radix-8 digits of a zero-extended 24-bit multiplier
  localparam int PP_W     = MANT_W + 3;  // 4x multiple plus sign
  localparam int PROD_W   = 2 * MANT_W;

  typedef logic [EXP_W+FRC_W:0] fp_word_t;
  typedef logic [EXP_W-1:0]     exp_t;
  typedef logic [FRC_W-1:0]     frc_t;
  typedef logic [MANT_W-1:0]    mant_t;
  typedef logic [PP_W-1:0]      pp_t;
  typedef logic [PROD_W-1:0]    prod_t;
  typedef logic [2:0]           rmode_t;

  localparam rmode_t RM_RNE = 3'd0;  // nearest, ties to even
  localparam rmode_t RM_RTZ = 3'd1;
  localparam rmode_t RM_RDN = 3'd2;  // toward -inf
  localparam rmode_t RM_RUP = 3'd3;  // toward +inf
  localparam rmode_t RM_RMM = 3'd4;  // nearest, ties away from zero

  localparam fp_word_t QNAN_WORD = 32'h7fc0_0000;

endpackage

`default_nettype wire

/* verilog/fpm_round_pack.sv */
// second stage; tiny results flush to signed zero, codes 5 to 7 truncate like RTZ
`timescale 1ns/1ps
`default_nettype none

module fpm_round_pack (
  input  logic              clk,
  input  logic              rst_n,
  fpm_operand_if.consumer   ops,
  input  fpm_pkg::prod_t    prod,
  output fpm_pkg::fp_word_t fp_z,
  output logic              ovrf,
  output logic              udrf
);
  import fpm_pkg::*;

  prod_t            prod_n;
  mant_t            kept;
  logic             guard;
  logic             rest;
  logic             round_up;
  logic [MANT_W:0]  rounded;
  logic             carry;
  frc_t             frc_z;
  logic [EXP_W+1:0] exp_sum;
  exp_t             exp_z;
  logic             ovf, udf;
  fp_word_t         z_d;
  logic             ovrf_d, udrf_d;
  logic             primed;

  assign prod_n = prod[PROD_W-1] ? prod : prod << 1;  // product in [1,4)
  assign kept   = prod_n[PROD_W-1 -: MANT_W];
  assign guard  = prod_n[PROD_W-MANT_W-1];
  assign rest   = |prod_n[PROD_W-MANT_W-2:0];  // round and sticky together

  always_comb begin
    case (ops.r_mode)
      RM_RNE:  round_up = guard & (rest | kept[0]);
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = ops.sign_z & (guard | rest);
      RM_RUP:  round_up = ~ops.sign_z & (guard | rest);
      RM_RMM:  round_up = guard;
      default: round_up = 1'b0;
    endcase
  end

  assign rounded = {1'b0, kept} + {{MANT_W{1'b0}}, round_up};
  assign carry   = rounded[MANT_W];  // only all ones + 1, fraction stays zero
  assign frc_z   = carry ? rounded[MANT_W-1:1] : rounded[FRC_W-1:0];

  // biased sum, bias removed below
  assign exp_sum = {2'b00, ops.exp_x} + {2'b00, ops.exp_y}
                 + {{(EXP_W+1){1'b0}}, prod[PROD_W-1]} + {{(EXP_W+1){1'b0}}, carry};
  assign ovf   = exp_sum >= (EXP_W+2)'(EXP_BIAS + (2**EXP_W) - 1);
  assign udf   = exp_sum <= (EXP_W+2)'(EXP_BIAS);
  assign exp_z = exp_t'(exp_sum - (EXP_W+2)'(EXP_BIAS));

  always_comb begin
    if (ops.nan_in) begin
      z_d = QNAN_WORD;
    end else if (ops.inf_in | ovf) begin
      z_d = {ops.sign_z, {EXP_W{1'b1}}, {FRC_W{1'b0}}};
    end else if (ops.zer_in | udf) begin
      z_d = {ops.sign_z, {(EXP_W+FRC_W){1'b0}}};
    end else begin
      z_d = {ops.sign_z, exp_z, frc_z};
    end
  end

  assign ovrf_d = ~ops.nan_in & (ops.inf_in | ovf);
  assign udrf_d = ~ops.nan_in & (ops.zer_in | udf);

  // the cleared input register looks like a zero operand on the first edge out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      primed <= 1'b0;
      fp_z   <= '0;
      ovrf   <= 1'b0;
      udrf   <= 1'b0;
    end else begin
      primed <= 1'b1;
      fp_z   <= z_d;
      ovrf   <= ovrf_d;
      udrf   <= primed & udrf_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/fpm_top.sv */
// two-cycle latency, one operation per clock, no handshake or back-pressure
`timescale 1ns/1ps
`default_nettype none

module fpm_top (
  input  logic              clk,
  input  logic              rst_n,
  input  fpm_pkg::rmode_t   r_mode,
  input  fpm_pkg::fp_word_t fp_x,
  input  fpm_pkg::fp_word_t fp_y,
  output fpm_pkg::fp_word_t fp_z,
  output logic              ovrf,
  output logic              udrf
);
  import fpm_pkg::*;

  mant_t               mult;
  logic [MANT_W:0]     mult3;
  logic [3:0]          digit_sel [PP_COUNT];
  logic [PP_COUNT-1:0] digit_neg;
  pp_t                 pp [PP_COUNT];
  prod_t               prod;

  fpm_operand_if ops ();

  fpm_unpack unpack_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .r_mode (r_mode),
    .fp_x   (fp_x),
    .fp_y   (fp_y),
    .ops    (ops)
  );

  booth_recoder recoder_i (
    .ops       (ops),
    .mult      (mult),
    .mult3     (mult3),
    .digit_sel (digit_sel),
    .digit_neg (digit_neg)
  );

  for (genvar i = 0; i < PP_COUNT; i++) begin : g_pp
    booth_selector sel_i (
      .mult  (mult),
      .mult3 (mult3),
      .sel   (digit_sel[i]),
      .neg   (digit_neg[i]),
      .pp    (pp[i])
    );
  end

  pp_accumulate acc_i (
    .pp   (pp),
    .neg  (digit_neg),
    .prod (prod)
  );

  fpm_round_pack round_i (
    .clk   (clk),
    .rst_n (rst_n),
    .ops   (ops),
    .prod  (prod),
    .fp_z  (fp_z),
    .ovrf  (ovrf),
    .udrf  (udrf)
  );

endmodule

`default_nettype wire

/* verilog/fpm_unpack.sv */
// first pipeline stage; an exponent field of zero is classified as zero whatever the fraction
`timescale 1ns/1ps
`default_nettype none

module fpm_unpack (
  input  logic              clk,
  input  logic              rst_n,
  input  fpm_pkg::rmode_t   r_mode,
  input  fpm_pkg::fp_word_t fp_x,
  input  fpm_pkg::fp_word_t fp_y,
  fpm_operand_if.producer   ops
);
  import fpm_pkg::*;

  fp_word_t x_q;
  fp_word_t y_q;
  rmode_t   mode_q;
  exp_t     ex;
  exp_t     ey;
  frc_t     fx;
  frc_t     fy;
  logic     inf_x, inf_y, zer_x, zer_y;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_q    <= '0;
      y_q    <= '0;
      mode_q <= RM_RNE;
    end else begin
      x_q    <= fp_x;
      y_q    <= fp_y;
      mode_q <= r_mode;
    end
  end

  assign ex = x_q[FRC_W +: EXP_W];
  assign ey = y_q[FRC_W +: EXP_W];
  assign fx = x_q[FRC_W-1:0];
  assign fy = y_q[FRC_W-1:0];

  assign zer_x = ~|ex;  // subnormals fold in here
  assign zer_y = ~|ey;
  assign inf_x = &ex & ~|fx;
  assign inf_y = &ey & ~|fy;

  assign ops.sign_z = x_q[EXP_W+FRC_W] ^ y_q[EXP_W+FRC_W];
  assign ops.exp_x  = ex;
  assign ops.exp_y  = ey;
  assign ops.mant_x = {1'b1, fx};
  assign ops.mant_y = {1'b1, fy};
  assign ops.r_mode = mode_q;
  // all-ones exponent with fraction, or inf times zero
  assign ops.nan_in = (&ex & |fx) | (&ey & |fy) | (inf_x & zer_y) | (inf_y & zer_x);
  assign ops.inf_in = inf_x | inf_y;
  assign ops.zer_in = zer_x | zer_y;

endmodule

`default_nettype wire

/* verilog/pp_accumulate.sv */
// sums the nine Booth rows modulo 2^48; exact because the mantissa product is unsigned
`timescale 1ns/1ps
`default_nettype none

module pp_accumulate (
  input  fpm_pkg::pp_t                 pp [fpm_pkg::PP_COUNT],
  input  logic [fpm_pkg::PP_COUNT-1:0] neg,
  output fpm_pkg::prod_t               prod
);
  import fpm_pkg::*;

  always_comb begin
    prod_t acc;
    prod_t row;
    acc = '0;
    for (int i = 0; i < PP_COUNT; i++) begin
      row = {{(PROD_W-PP_W){pp[i][PP_W-1]}}, pp[i]};  // sign extend
      // neg bit completes the two's complement at the row weight
      acc = acc + (row << (3*i)) + (prod_t'(neg[i]) << (3*i));
    end
    prod = acc;
  end

endmodule

`default_nettype wire
